/* Makefile */
SRCS := $(wildcard verilog/*.sv) $(wildcard testbench/*.sv)
SIM := obj_dir/Vopenfire_core_tb

.PHONY: all run check clean

all: check

$(SIM): openfire_core.f $(SRCS)
	verilator --binary --timing --assert -f openfire_core.f --top-module openfire_core_tb -Mdir obj_dir

run: $(SIM)
	./$(SIM) | tee sim.log

check: run
	@if grep -q "TEST RESULT: FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* openfire_core.f */
verilog/openfire_pkg.sv
verilog/openfire_fetch.sv
verilog/openfire_decode.sv
verilog/openfire_regfile.sv
verilog/openfire_execute.sv
verilog/openfire_core.sv
testbench/openfire_core_properties.sv
testbench/openfire_core_tb.sv

/* testbench/openfire_core_properties.sv */
// openfire core handshake and write-port properties, bound to the core top
`default_nettype none
`timescale 1ns/1ps

module openfire_core_properties (
	input logic clock,
	input logic reset,
	input logic imem_req,
	input logic imem_ack,
	input openfire_pkg::pc_t imem_addr,
	input openfire_pkg::wb_t wb
);

	req_rise_ack_low: assert property (@(posedge clock) disable iff (reset)
		$rose(imem_req) |-> !imem_ack)
		else $error("imem_req rose while imem_ack was high");

	addr_stable: assert property (@(posedge clock) disable iff (reset)
		imem_req && $past(imem_req) |-> $stable(imem_addr))
		else $error("imem_addr changed during an open request");

	req_fall_after_ack: assert property (@(posedge clock) disable iff (reset)
		$fell(imem_req) |-> $past(imem_ack))
		else $error("imem_req dropped without an ack");

	no_r0_write: assert property (@(posedge clock) disable iff (reset)
		wb.valid |-> wb.addr != '0)
		else $error("register write to r0 on wb");

endmodule

bind openfire_core openfire_core_properties props_i (
	.clock(clock), .reset(reset), .imem_req(imem_req),
	.imem_ack(imem_ack), .imem_addr(imem_addr), .wb(wb)
);

`default_nettype wire

/* testbench/openfire_core_tb.sv */
// openfire core testbench: memory responder with random latency, program image, write checks
`default_nettype none
`timescale 1ns/1ps

module openfire_core_tb;

	localparam int prog_words = 37;
	localparam int num_writes = 27;
	localparam int worst_fetch_cycles = 12;	// 3 wait cycles plus handshake turnaround
	localparam int timeout_cycles = prog_words * worst_fetch_cycles * 4 + 8;

	logic clock;
	logic reset;
	logic imem_req;
	openfire_pkg::pc_t imem_addr;
	logic imem_ack;
	openfire_pkg::word_t imem_data;
	openfire_pkg::wb_t wb;

	openfire_pkg::word_t program_mem [prog_words];
	openfire_pkg::reg_addr_t exp_addr [num_writes];
	openfire_pkg::word_t exp_data [num_writes];
	string exp_name [num_writes];
	int write_idx;

	openfire_core #(.reset_pc(32'h0)) dut_i (
		.clock(clock), .reset(reset), .imem_req(imem_req), .imem_addr(imem_addr),
		.imem_ack(imem_ack), .imem_data(imem_data), .wb(wb)
	);

	function automatic openfire_pkg::word_t read_program(input openfire_pkg::pc_t addr);
		if (addr < prog_words * 4)
			return program_mem[addr[31:2]];
		return 32'h0;	// ADD r0,r0,r0 past the image
	endfunction

	task automatic add_write(input int idx, input string name, input int rd, input logic [31:0] v);
		exp_name[idx] = name;
		exp_addr[idx] = rd[4:0];
		exp_data[idx] = v;
	endtask

	initial
	begin
		program_mem = '{
			32'h20200005, 32'h2040FFFF, 32'h00611000, 32'h10A10800,	// addi r1, addi r2, add, addk
			32'h08800000, 32'h04C11800, 32'h80E11800, 32'h85011800,	// addc, rsub, or, and
			32'h89211800, 32'h8D411800, 32'hB0001234, 32'h21605678,	// xor, andn, imm, addi
			32'h21808000, 32'h91AC0001, 32'h91C10001, 32'h91E10021,	// addi neg, sra, sra, src
			32'h920C0041, 32'h2A400080, 32'h92320060, 32'h92700061,	// srl, addic, sext8, sext16
			32'h16860801, 32'h16A60803, 32'hBC010008, 32'h22C00016,	// cmp, cmpu, beqi untaken
			32'hBC21000C, 32'h22E00001, 32'h22E00002, 32'hBE81000C,	// bnei taken, skipped, bgtid
			32'h23000018, 32'h23200001, 32'hB9F40010, 32'h2340001A,	// slot, skipped, brlid, slot
			32'h2360001B, 32'hB8000000, 32'hB60F0008, 32'h2380001C,	// return point, bri 0, rtsd
			32'h23A00001	// after the rtsd slot, never runs
		};
		add_write(0, "addi_pos", 1, 32'h00000005);
		add_write(1, "addi_neg", 2, 32'hFFFFFFFF);
		add_write(2, "add_carry_out", 3, 32'h00000004);
		add_write(3, "addk", 5, 32'h0000000A);
		add_write(4, "addc_kept_carry", 4, 32'h00000001);
		add_write(5, "rsub", 6, 32'hFFFFFFFF);
		add_write(6, "or", 7, 32'h00000005);
		add_write(7, "and", 8, 32'h00000004);
		add_write(8, "xor", 9, 32'h00000001);
		add_write(9, "andn", 10, 32'h00000001);
		add_write(10, "imm_prefix", 11, 32'h12345678);
		add_write(11, "addi_sext", 12, 32'hFFFF8000);
		add_write(12, "sra_neg", 13, 32'hFFFFC000);
		add_write(13, "sra_carry", 14, 32'h00000002);
		add_write(14, "src", 15, 32'h80000002);
		add_write(15, "srl", 16, 32'h7FFFC000);
		add_write(16, "addic_srl_carry", 18, 32'h00000080);
		add_write(17, "sext8", 17, 32'hFFFFFF80);
		add_write(18, "sext16", 19, 32'hFFFFC000);
		add_write(19, "cmp", 20, 32'h00000006);
		add_write(20, "cmpu", 21, 32'h80000006);
		add_write(21, "beq_untaken", 22, 32'h00000016);
		add_write(22, "bgt_delay_slot", 24, 32'h00000018);
		add_write(23, "brl_link", 15, 32'h00000078);
		add_write(24, "brl_delay_slot", 26, 32'h0000001A);
		add_write(25, "rtsd_delay_slot", 28, 32'h0000001C);
		add_write(26, "rtsd_return", 27, 32'h0000001B);
	end

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	initial
	begin
		reset = 1'b1;
		imem_ack = 1'b0;
		imem_data = '0;
		repeat (8) @(posedge clock);
		reset <= 1'b0;
	end

	// four-phase responder, sampling at the falling edge
	initial
	begin
		int wait_cycles;
		void'($urandom(32'h356));
		forever
		begin
			@(negedge clock);
			if (!reset && imem_req && !imem_ack)
			begin
				wait_cycles = $urandom_range(3, 0);
				repeat (wait_cycles) @(posedge clock);
				@(posedge clock);
				imem_ack <= 1'b1;
				imem_data <= read_program(imem_addr);
				do
					@(negedge clock);
				while (imem_req);
				@(posedge clock);
				imem_ack <= 1'b0;
			end
		end
	end

	// every write is compared with the next table entry
	initial
	begin
		write_idx = 0;
		while (write_idx < num_writes)
		begin
			@(negedge clock);
			if (!reset && wb.valid)
			begin
				assert (wb.addr == exp_addr[write_idx] && wb.data == exp_data[write_idx])
				else
				begin
					$display("Error: %s expected r%0d=%h actual r%0d=%h", exp_name[write_idx],
						exp_addr[write_idx], exp_data[write_idx], wb.addr, wb.data);
					$display("TEST RESULT: FAIL");
					$fatal(1, "write mismatch");
				end
				write_idx++;
			end
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

	initial
	begin
		#(timeout_cycles * 20);
		$display("watchdog expired after %0d of %0d expected writes", write_idx, num_writes);
		$display("TEST RESULT: FAIL");
		$fatal(1, "timeout");
	end

endmodule

`default_nettype wire

/* verilog/openfire_core.sv */
// openfire core top: fetch, decode, register file and execute wired in order
`default_nettype none
`timescale 1ns/1ps

module openfire_core #(
	parameter openfire_pkg::pc_t reset_pc = 32'h0
) (
	input logic clock,
	input logic reset,
	output logic imem_req,
	output openfire_pkg::pc_t imem_addr,
	input logic imem_ack,
	input openfire_pkg::word_t imem_data,
	output openfire_pkg::wb_t wb
);

	openfire_pkg::fetch_word_t fetch_word;
	openfire_pkg::decode_ctrl_t ctrl;
	openfire_pkg::redirect_t redirect;
	openfire_pkg::word_t ra_data;
	openfire_pkg::word_t rb_data;

	openfire_fetch #(.reset_pc(reset_pc)) fetch_i (
		.clock(clock), .reset(reset), .redirect(redirect),
		.imem_req(imem_req), .imem_addr(imem_addr), .imem_ack(imem_ack),
		.imem_data(imem_data), .fetch_word(fetch_word)
	);

	openfire_decode decode_i (
		.clock(clock), .reset(reset), .fetch_word(fetch_word),
		.redirect(redirect), .ctrl(ctrl)
	);

	openfire_regfile regfile_i (
		.clock(clock), .reset(reset), .ra(ctrl.ra), .rb(ctrl.rb),
		.ra_data(ra_data), .rb_data(rb_data), .wb(wb)
	);

	openfire_execute #(.reset_pc(reset_pc)) execute_i (
		.clock(clock), .reset(reset), .ctrl(ctrl), .ra_data(ra_data),
		.rb_data(rb_data), .wb(wb), .redirect(redirect)
	);

endmodule

`default_nettype wire

/* verilog/openfire_decode.sv */
// openfire decode stage: registered execute controls, IMM prefix, bubble on flush or empty cycle
`default_nettype none
`timescale 1ns/1ps

module openfire_decode (
	input logic clock,
	input logic reset,
	input openfire_pkg::fetch_word_t fetch_word,
	input openfire_pkg::redirect_t redirect,
	output openfire_pkg::decode_ctrl_t ctrl
);

	openfire_pkg::opcode_t opcode;
	openfire_pkg::word_t instr;
	openfire_pkg::decode_ctrl_t next_ctrl;
	logic [15:0] imm_hi;	// upper half from IMM
	logic imm_valid;	// previous instruction was IMM
	logic imm_form;	// type B, immediate operand
	logic c_bit;
	logic k_bit;
	logic [2:0] cond;
	logic is_imm;

	assign instr = fetch_word.instruction;
	assign opcode = openfire_pkg::opcode_t'(instr[31:26]);
	assign imm_form = instr[29];
	assign c_bit = instr[27];	// carry in
	assign k_bit = instr[28];	// keep carry
	assign cond = instr[23:21];
	assign is_imm = (opcode == openfire_pkg::op_imm);

	always_comb
	begin
		next_ctrl = openfire_pkg::nop_ctrl;
		next_ctrl.valid = 1'b1;	// every word advances the expected pc
		next_ctrl.pc = fetch_word.pc;
		next_ctrl.rd = instr[25:21];
		next_ctrl.ra = instr[20:16];
		next_ctrl.rb = instr[15:11];
		next_ctrl.immediate = imm_valid ? {imm_hi, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
		next_ctrl.b_sel = imm_form ? openfire_pkg::alu_b_imm : openfire_pkg::alu_b_rb;
		next_ctrl.alu_fn = openfire_pkg::alu_add;
		next_ctrl.write_enable = 1'b1;	// most instructions write rd
		case (opcode)
			openfire_pkg::op_add, openfire_pkg::op_addc, openfire_pkg::op_addk,
			openfire_pkg::op_addkc, openfire_pkg::op_addi, openfire_pkg::op_addic,
			openfire_pkg::op_addik, openfire_pkg::op_addikc:
			begin
				next_ctrl.c_sel = c_bit ? openfire_pkg::alu_c_carry : openfire_pkg::alu_c_zero;
				next_ctrl.update_carry = !k_bit;
			end
			openfire_pkg::op_rsub, openfire_pkg::op_rsubc, openfire_pkg::op_rsubk,
			openfire_pkg::op_rsubkc, openfire_pkg::op_rsubi, openfire_pkg::op_rsubic,
			openfire_pkg::op_rsubik, openfire_pkg::op_rsubikc:
			begin
				next_ctrl.a_sel = openfire_pkg::alu_a_ra_bar;	// rb + ~ra + 1
				next_ctrl.c_sel = c_bit ? openfire_pkg::alu_c_carry : openfire_pkg::alu_c_one;
				next_ctrl.update_carry = !k_bit;
				if (opcode == openfire_pkg::op_rsubk && instr[0])	// CMP / CMPU
					next_ctrl.alu_fn = instr[1] ? openfire_pkg::alu_compare_uns : openfire_pkg::alu_compare;
			end
			openfire_pkg::op_or, openfire_pkg::op_ori:
				next_ctrl.alu_fn = openfire_pkg::alu_logic_or;
			openfire_pkg::op_and, openfire_pkg::op_andi:
				next_ctrl.alu_fn = openfire_pkg::alu_logic_and;
			openfire_pkg::op_xor, openfire_pkg::op_xori:
				next_ctrl.alu_fn = openfire_pkg::alu_logic_xor;
			openfire_pkg::op_andn, openfire_pkg::op_andni:
			begin
				next_ctrl.alu_fn = openfire_pkg::alu_logic_and;
				next_ctrl.b_sel = imm_form ? openfire_pkg::alu_b_imm_bar : openfire_pkg::alu_b_rb_bar;
			end
			openfire_pkg::op_shift:
			begin
				next_ctrl.c_sel = openfire_pkg::alu_c_carry;
				next_ctrl.update_carry = !(instr[6] && instr[5]);	// shifts only, sext leaves carry
				case (instr[6:0])	// function in the low immediate bits
					7'h01: next_ctrl.alu_fn = openfire_pkg::alu_shift_r_arith;
					7'h21: next_ctrl.alu_fn = openfire_pkg::alu_shift_r_carry;
					7'h41: next_ctrl.alu_fn = openfire_pkg::alu_shift_r_log;
					7'h60: next_ctrl.alu_fn = openfire_pkg::alu_sext8;
					7'h61: next_ctrl.alu_fn = openfire_pkg::alu_sext16;
					default:
					begin
						next_ctrl.write_enable = 1'b0;
						next_ctrl.update_carry = 1'b0;
					end
				endcase
			end
			openfire_pkg::op_br, openfire_pkg::op_bri:
			begin
				next_ctrl.branch = 1'b1;
				next_ctrl.a_sel = openfire_pkg::alu_a_pc;
				next_ctrl.cmp_fn = openfire_pkg::cmp_one;	// always taken
				next_ctrl.delay = instr[20];
				next_ctrl.absolute = instr[19];
				next_ctrl.write_enable = instr[18];	// link into rd
			end
			openfire_pkg::op_bcc, openfire_pkg::op_bcci:
			begin
				next_ctrl.branch = 1'b1;
				next_ctrl.a_sel = openfire_pkg::alu_a_pc;
				next_ctrl.cmp_fn = (cond <= 3'd5) ? openfire_pkg::cmp_fn_t'(cond + 3'd2)
					: openfire_pkg::cmp_zero;	// eq ne lt le gt ge
				next_ctrl.delay = instr[25];
				next_ctrl.write_enable = 1'b0;
			end
			openfire_pkg::op_rtsd:
			begin
				next_ctrl.branch = 1'b1;	// ra + imm
				next_ctrl.cmp_fn = openfire_pkg::cmp_one;
				next_ctrl.delay = 1'b1;
				next_ctrl.write_enable = 1'b0;
			end
			default:
				next_ctrl.write_enable = 1'b0;	// IMM and undefined opcodes
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset || redirect.valid)
		begin
			ctrl <= openfire_pkg::nop_ctrl;
			imm_valid <= 1'b0;
		end
		else if (fetch_word.valid)
		begin
			ctrl <= next_ctrl;
			imm_valid <= is_imm;
		end
		else
			ctrl <= openfire_pkg::nop_ctrl;	// bubble, prefix kept
	end

	always_ff @(posedge clock)
	begin
		if (fetch_word.valid && is_imm)
			imm_hi <= instr[15:0];
	end

endmodule

`default_nettype wire

/* verilog/openfire_execute.sv */
// openfire execute stage: ALU, carry, branch comparator, expected-pc squash and redirect
`default_nettype none
`timescale 1ns/1ps

module openfire_execute #(
	parameter openfire_pkg::pc_t reset_pc = 32'h0
) (
	input logic clock,
	input logic reset,
	input openfire_pkg::decode_ctrl_t ctrl,
	input openfire_pkg::word_t ra_data,
	input openfire_pkg::word_t rb_data,
	output openfire_pkg::wb_t wb,
	output openfire_pkg::redirect_t redirect
);

	openfire_pkg::pc_t expected_pc;	// architectural next pc
	openfire_pkg::pc_t pending_target;	// target held across a delay slot
	logic delay_pending;	// current instruction is a delay slot
	logic carry;	// MSR[C]
	openfire_pkg::word_t a_op;
	openfire_pkg::word_t b_op;
	openfire_pkg::word_t result;
	openfire_pkg::word_t raw_target;
	openfire_pkg::pc_t target;
	logic [32:0] sum;
	logic c_in;
	logic c_out;
	logic accepted;
	logic cond_true;
	logic taken;

	assign accepted = ctrl.valid && (ctrl.pc == expected_pc);	// squash off-path words
	assign sum = {1'b0, a_op} + {1'b0, b_op} + {32'b0, c_in};
	assign raw_target = ctrl.absolute ? b_op : sum[31:0];
	assign target = {raw_target[31:2], 2'b00};
	assign taken = accepted && ctrl.branch && cond_true;

	always_comb
	begin
		case (ctrl.a_sel)
			openfire_pkg::alu_a_ra: a_op = ra_data;
			openfire_pkg::alu_a_ra_bar: a_op = ~ra_data;
			openfire_pkg::alu_a_pc: a_op = ctrl.pc;
			default: a_op = '0;
		endcase
		case (ctrl.b_sel)
			openfire_pkg::alu_b_rb: b_op = rb_data;
			openfire_pkg::alu_b_rb_bar: b_op = ~rb_data;	// ANDN
			openfire_pkg::alu_b_imm: b_op = ctrl.immediate;
			default: b_op = ~ctrl.immediate;
		endcase
		case (ctrl.c_sel)
			openfire_pkg::alu_c_one: c_in = 1'b1;
			openfire_pkg::alu_c_carry: c_in = carry;
			default: c_in = 1'b0;
		endcase
	end

	always_comb
	begin
		c_out = sum[32];
		case (ctrl.alu_fn)
			openfire_pkg::alu_compare: result = {$signed(rb_data) < $signed(ra_data), sum[30:0]};
			openfire_pkg::alu_compare_uns: result = {rb_data < ra_data, sum[30:0]};
			openfire_pkg::alu_logic_or: result = a_op | b_op;
			openfire_pkg::alu_logic_and: result = a_op & b_op;
			openfire_pkg::alu_logic_xor: result = a_op ^ b_op;
			openfire_pkg::alu_shift_r_arith: result = {a_op[31], a_op[31:1]};
			openfire_pkg::alu_shift_r_carry: result = {c_in, a_op[31:1]};
			openfire_pkg::alu_shift_r_log: result = {1'b0, a_op[31:1]};
			openfire_pkg::alu_sext8: result = {{24{a_op[7]}}, a_op[7:0]};
			openfire_pkg::alu_sext16: result = {{16{a_op[15]}}, a_op[15:0]};
			default: result = sum[31:0];
		endcase
		if (ctrl.alu_fn inside {openfire_pkg::alu_shift_r_arith, openfire_pkg::alu_shift_r_carry,
			openfire_pkg::alu_shift_r_log})
			c_out = a_op[0];	// bit shifted out
	end

	// comparator on ra
	always_comb
	begin
		case (ctrl.cmp_fn)
			openfire_pkg::cmp_one: cond_true = 1'b1;
			openfire_pkg::cmp_eq: cond_true = (ra_data == '0);
			openfire_pkg::cmp_ne: cond_true = (ra_data != '0);
			openfire_pkg::cmp_lt: cond_true = ra_data[31];
			openfire_pkg::cmp_le: cond_true = ra_data[31] || (ra_data == '0);
			openfire_pkg::cmp_gt: cond_true = !ra_data[31] && (ra_data != '0);
			openfire_pkg::cmp_ge: cond_true = !ra_data[31];
			default: cond_true = 1'b0;
		endcase
	end

	always_comb
	begin
		wb.valid = accepted && ctrl.write_enable && (ctrl.rd != '0);
		wb.addr = ctrl.rd;
		wb.data = ctrl.branch ? ctrl.pc : result;	// link value for BRL
		redirect.valid = accepted && (delay_pending || (taken && !ctrl.delay));
		redirect.target = delay_pending ? pending_target : target;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			expected_pc <= reset_pc;
			delay_pending <= 1'b0;
			carry <= 1'b0;
		end
		else if (accepted)
		begin
			expected_pc <= redirect.valid ? redirect.target : ctrl.pc + 32'd4;
			delay_pending <= taken && ctrl.delay && !delay_pending;
			if (ctrl.update_carry)
				carry <= c_out;
		end
	end

	always_ff @(posedge clock)
	begin
		if (taken && ctrl.delay)
			pending_target <= target;	// used when the slot retires
	end

endmodule

`default_nettype wire

/* verilog/openfire_fetch.sv */
// openfire fetch unit: pc, four-phase instruction memory requester, drops words fetched before a redirect
`default_nettype none
`timescale 1ns/1ps

module openfire_fetch #(
	parameter openfire_pkg::pc_t reset_pc = 32'h0
) (
	input logic clock,
	input logic reset,
	input openfire_pkg::redirect_t redirect,
	output logic imem_req,
	output openfire_pkg::pc_t imem_addr,
	input logic imem_ack,
	input openfire_pkg::word_t imem_data,
	output openfire_pkg::fetch_word_t fetch_word
);

	typedef enum logic [1:0] {idle, wait_ack, wait_release} fetch_state_t;

	fetch_state_t state;
	openfire_pkg::pc_t pc;	// address of the next request
	openfire_pkg::pc_t next_pc;
	logic stale;	// open request predates a redirect
	logic word_valid;
	openfire_pkg::pc_t word_pc;
	openfire_pkg::word_t word_instr;

	assign next_pc = redirect.valid ? redirect.target : pc;
	assign imem_req = (state == wait_ack);	// addr is held in imem_addr while high
	assign fetch_word = '{valid: word_valid, pc: word_pc, instruction: word_instr};

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= idle;
			pc <= reset_pc;
			stale <= 1'b0;
			word_valid <= 1'b0;
		end
		else
		begin
			word_valid <= 1'b0;	// one-cycle pulse per accepted word
			pc <= next_pc;
			if (redirect.valid)
				stale <= 1'b1;	// anything in flight is now off path
			case (state)
				idle:
					if (!imem_ack)	// previous ack seen low
					begin
						state <= wait_ack;
						pc <= next_pc + 32'd4;
						stale <= 1'b0;
					end
				wait_ack:
					if (imem_ack)
					begin
						state <= wait_release;
						word_valid <= !stale && !redirect.valid;
					end
				wait_release:
					if (!imem_ack)
						state <= idle;
				default: state <= idle;
			endcase
		end
	end

	// request address and captured word
	always_ff @(posedge clock)
	begin
		if (state == idle && !imem_ack)
			imem_addr <= next_pc;
		if (state == wait_ack && imem_ack)
		begin
			word_pc <= imem_addr;
			word_instr <= imem_data;
		end
	end

endmodule

`default_nettype wire

/* verilog/openfire_pkg.sv */
// openfire core shared types: opcodes, datapath selectors and stage-to-stage records
`default_nettype none

package openfire_pkg;

	typedef logic [31:0] word_t;	// data word
	typedef logic [31:0] pc_t;	// byte address, low two bits zero
	typedef logic [4:0] reg_addr_t;	// register index

	// major opcodes, instruction[31:26]
	typedef enum logic [5:0] {
		op_add = 6'h00, op_rsub = 6'h01, op_addc = 6'h02, op_rsubc = 6'h03,
		op_addk = 6'h04, op_rsubk = 6'h05, op_addkc = 6'h06, op_rsubkc = 6'h07,
		op_addi = 6'h08, op_rsubi = 6'h09, op_addic = 6'h0a, op_rsubic = 6'h0b,
		op_addik = 6'h0c, op_rsubik = 6'h0d, op_addikc = 6'h0e, op_rsubikc = 6'h0f,
		op_or = 6'h20, op_and = 6'h21, op_xor = 6'h22, op_andn = 6'h23,
		op_shift = 6'h24, op_br = 6'h26, op_bcc = 6'h27, op_ori = 6'h28,
		op_andi = 6'h29, op_xori = 6'h2a, op_andni = 6'h2b, op_imm = 6'h2c,
		op_rtsd = 6'h2d, op_bri = 6'h2e, op_bcci = 6'h2f
	} opcode_t;

	typedef enum logic [1:0] {alu_a_ra, alu_a_ra_bar, alu_a_pc, alu_a_zero} alu_a_sel_t;
	typedef enum logic [1:0] {alu_b_rb, alu_b_rb_bar, alu_b_imm, alu_b_imm_bar} alu_b_sel_t;
	typedef enum logic [1:0] {alu_c_zero, alu_c_one, alu_c_carry} alu_c_sel_t;

	typedef enum logic [3:0] {
		alu_add, alu_compare, alu_compare_uns, alu_logic_or, alu_logic_and, alu_logic_xor,
		alu_shift_r_arith, alu_shift_r_carry, alu_shift_r_log, alu_sext8, alu_sext16
	} alu_fn_t;

	// branch conditions, all tested on ra
	typedef enum logic [2:0] {cmp_zero, cmp_one, cmp_eq, cmp_ne, cmp_lt, cmp_le, cmp_gt, cmp_ge} cmp_fn_t;

	typedef struct packed {
		logic valid;
		pc_t pc;
		word_t instruction;
	} fetch_word_t;

	typedef struct packed {
		logic valid;
		pc_t pc;
		reg_addr_t ra;
		reg_addr_t rb;
		reg_addr_t rd;
		word_t immediate;
		alu_a_sel_t a_sel;
		alu_b_sel_t b_sel;
		alu_c_sel_t c_sel;
		alu_fn_t alu_fn;
		cmp_fn_t cmp_fn;
		logic branch;	// comparator decides the redirect
		logic delay;	// branch has a delay slot
		logic absolute;	// target is operand b alone
		logic write_enable;
		logic update_carry;
	} decode_ctrl_t;

	typedef struct packed {
		logic valid;
		reg_addr_t addr;
		word_t data;
	} wb_t;

	typedef struct packed {
		logic valid;
		pc_t target;
	} redirect_t;

	// bubble: OR r0,r0,r0 that writes nothing
	localparam decode_ctrl_t nop_ctrl = '{
		valid: 1'b0, pc: '0, ra: '0, rb: '0, rd: '0, immediate: '0,
		a_sel: alu_a_ra, b_sel: alu_b_rb, c_sel: alu_c_zero,
		alu_fn: alu_logic_or, cmp_fn: cmp_zero,
		branch: 1'b0, delay: 1'b0, absolute: 1'b0, write_enable: 1'b0, update_carry: 1'b0
	};

endpackage

`default_nettype wire

/* verilog/openfire_regfile.sv */
// openfire register file: 32 words, two combinational reads, one write, r0 reads zero
`default_nettype none
`timescale 1ns/1ps

module openfire_regfile (
	input logic clock,
	input logic reset,
	input openfire_pkg::reg_addr_t ra,
	input openfire_pkg::reg_addr_t rb,
	output openfire_pkg::word_t ra_data,
	output openfire_pkg::word_t rb_data,
	input openfire_pkg::wb_t wb
);

	localparam int num_regs = 32;	// fixed by the ISA

	openfire_pkg::word_t regs [num_regs];

	assign ra_data = regs[ra];
	assign rb_data = regs[rb];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < num_regs; i++)
				regs[i] <= '0;
		end
		else if (wb.valid && wb.addr != '0)	// r0 never written
			regs[wb.addr] <= wb.data;
	end

endmodule

`default_nettype wire
